//--- src/memTestPkg.sv
`default_nettype none

package memTestPkg;

	// ------------------------------------------------------------------------
	// sizes and fixed values
	// ------------------------------------------------------------------------
	// one sdram word
	localparam int DATA_WIDTH = 16;
	// controller user port address
	localparam int ADDRESS_WIDTH = 25;
	// words under test, one board switch each
	localparam int TEST_WORD_COUNT = 10;
	localparam int SLOT_INDEX_WIDTH = 4;
	// written word is base plus address
	localparam logic [DATA_WIDTH-1:0] DATA_BASE_VALUE = 16'd100;
	localparam int STARTUP_SETTLE_CYCLES = 10;
	localparam int READBACK_PAUSE_CYCLES = 20;
	// shared wait counter, sized by the longer wait
	localparam int WAIT_COUNT_WIDTH = $clog2(READBACK_PAUSE_CYCLES);
	// display value as a plain binary number
	localparam int DISPLAY_WIDTH = 20;
	localparam logic [DISPLAY_WIDTH-1:0] IDLE_DISPLAY_VALUE = 20'd191919;

	// ------------------------------------------------------------------------
	// states and opcodes
	// ------------------------------------------------------------------------
	typedef enum logic [3:0] {
		startupWait,
		waitControllerReady,
		settle,
		issueWrite,
		awaitWriteDone,
		readbackPause,
		issueRead,
		awaitReadDone,
		complete
	} sequencerState_t;

	// write is high, as the controller's isWriting line
	typedef enum logic {
		accessRead  = 1'b0,
		accessWrite = 1'b1
	} accessKind_t;

	// ------------------------------------------------------------------------
	// bundles
	// ------------------------------------------------------------------------
	typedef struct packed {
		logic [ADDRESS_WIDTH-1:0] address;
		logic [DATA_WIDTH-1:0] writeData;
		accessKind_t kind;
	} memRequest_t;

	typedef struct packed {
		logic valid;
		accessKind_t kind;
		logic [SLOT_INDEX_WIDTH-1:0] slotIndex;
		logic [DATA_WIDTH-1:0] data;
	} captureEvent_t;

	typedef struct packed {
		logic valid;
		logic [SLOT_INDEX_WIDTH-1:0] slotIndex;
		logic showWritten;
	} slotSelect_t;

endpackage

`default_nettype wire

//--- src/memTestSequencer.sv
`default_nettype none

module memTestSequencer (
	input wire logic clock143Mhz,
	input wire logic reset_n,
	// request side of the user port
	output memTestPkg::memRequest_t memRequest,
	output logic memRequestValid,
	// controller responses
	input wire logic memAccepted,
	input wire logic memBusy,
	input wire logic memReadValid,
	input wire logic [memTestPkg::DATA_WIDTH-1:0] memReadData,
	// to the result store
	output memTestPkg::captureEvent_t captureEvent,
	output logic testDone
);
	import memTestPkg::*;

	sequencerState_t state;
	// settle and pause waits share this
	logic [WAIT_COUNT_WIDTH-1:0] waitCount;
	// address of the current access
	logic [SLOT_INDEX_WIDTH-1:0] slotCount;
	logic lastSlot;
	logic readPhase;

	assign lastSlot = (slotCount == SLOT_INDEX_WIDTH'(TEST_WORD_COUNT - 1));
	assign readPhase = (state == issueRead) || (state == awaitReadDone);

	// ------------------------------------------------------------------------
	// state machine
	// ------------------------------------------------------------------------
	always_ff @(posedge clock143Mhz) begin
		if (!reset_n) begin
			state <= startupWait;
			waitCount <= '0;
			slotCount <= '0;
		end else begin
			unique case (state)
				// give the controller time to go busy
				startupWait: begin
					if (waitCount == WAIT_COUNT_WIDTH'(STARTUP_SETTLE_CYCLES - 1)) begin
						waitCount <= '0;
						state <= waitControllerReady;
					end else begin
						waitCount <= waitCount + 1'b1;
					end
				end
				// controller init still running
				waitControllerReady: begin
					if (!memBusy) begin
						state <= settle;
					end
				end
				// short pause once init is over
				settle: begin
					if (waitCount == WAIT_COUNT_WIDTH'(STARTUP_SETTLE_CYCLES - 1)) begin
						waitCount <= '0;
						slotCount <= '0;
						state <= issueWrite;
					end else begin
						waitCount <= waitCount + 1'b1;
					end
				end
				// hold the request until taken
				issueWrite: begin
					if (memAccepted) begin
						state <= awaitWriteDone;
					end
				end
				// busy low after acceptance ends the access
				awaitWriteDone: begin
					if (!memBusy) begin
						if (lastSlot) begin
							slotCount <= '0;
							state <= readbackPause;
						end else begin
							slotCount <= slotCount + 1'b1;
							state <= issueWrite;
						end
					end
				end
				// gap between the write and read loops
				readbackPause: begin
					if (waitCount == WAIT_COUNT_WIDTH'(READBACK_PAUSE_CYCLES - 1)) begin
						waitCount <= '0;
						state <= issueRead;
					end else begin
						waitCount <= waitCount + 1'b1;
					end
				end
				issueRead: begin
					if (memAccepted) begin
						state <= awaitReadDone;
					end
				end
				// read data arrives somewhere in the busy window
				awaitReadDone: begin
					if (!memBusy) begin
						if (lastSlot) begin
							state <= complete;
						end else begin
							slotCount <= slotCount + 1'b1;
							state <= issueRead;
						end
					end
				end
				// test over, stays here until reset
				complete: begin
					state <= complete;
				end
				default: begin
					state <= startupWait;
				end
			endcase
		end
	end

	// ------------------------------------------------------------------------
	// user port request and capture
	// ------------------------------------------------------------------------
	// request only depends on registered state, so it is stable in issue states
	always_comb begin
		memRequestValid = (state == issueWrite) || (state == issueRead);
		memRequest.address = ADDRESS_WIDTH'(slotCount);
		memRequest.writeData = DATA_BASE_VALUE + DATA_WIDTH'(slotCount);
		memRequest.kind = readPhase ? accessRead : accessWrite;
	end

	// write captured on acceptance, read on read-valid
	always_comb begin
		captureEvent.valid = ((state == issueWrite) && memAccepted)
			|| (memReadValid && ((state == awaitReadDone)
			|| ((state == issueRead) && memAccepted)));
		captureEvent.kind = readPhase ? accessRead : accessWrite;
		captureEvent.slotIndex = slotCount;
		captureEvent.data = readPhase ? memReadData : memRequest.writeData;
	end

	assign testDone = (state == complete);

	// ------------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------------
	// pending request keeps valid and payload until accepted
	requestHeld: assert property (@(posedge clock143Mhz) disable iff (!reset_n)
		memRequestValid && !memAccepted |=> memRequestValid && $stable(memRequest))
		else $error("request changed while waiting for acceptance");

endmodule

`default_nettype wire

//--- src/slotSelectDecoder.sv
`default_nettype none

module slotSelectDecoder (
	input wire logic clock143Mhz,
	input wire logic reset_n,
	// board inputs, not related to the clock
	input wire logic [memTestPkg::TEST_WORD_COUNT-1:0] switches,
	input wire logic showWrittenButton,
	output memTestPkg::slotSelect_t slotSelect
);
	import memTestPkg::*;

	// button in the top bit, switches below
	logic [TEST_WORD_COUNT:0] boardMeta;
	logic [TEST_WORD_COUNT:0] boardSync;
	logic anySwitch;
	logic [SLOT_INDEX_WIDTH-1:0] firstSwitch;

	// two-flop synchronizer
	always_ff @(posedge clock143Mhz) begin
		boardMeta <= {showWrittenButton, switches};
		boardSync <= boardMeta;
	end

	// lowest-numbered set switch wins
	// scan from the top so lower indices overwrite
	always_comb begin
		anySwitch = 1'b0;
		firstSwitch = '0;
		for (int i = TEST_WORD_COUNT - 1; i >= 0; i--) begin
			if (boardSync[i]) begin
				anySwitch = 1'b1;
				firstSwitch = SLOT_INDEX_WIDTH'(i);
			end
		end
	end

	// registered selection
	always_ff @(posedge clock143Mhz) begin
		if (!reset_n) begin
			slotSelect <= '0;
		end else begin
			slotSelect.valid <= anySwitch;
			slotSelect.slotIndex <= firstSwitch;
			// pressed means show the written word
			slotSelect.showWritten <= boardSync[TEST_WORD_COUNT];
		end
	end

	// a valid selection names one of the tested slots
	slotInRange: assert property (@(posedge clock143Mhz) disable iff (!reset_n)
		slotSelect.valid |-> slotSelect.slotIndex < SLOT_INDEX_WIDTH'(TEST_WORD_COUNT))
		else $error("selected slot out of range");

endmodule

`default_nettype wire

//--- src/resultStore.sv
`default_nettype none

module resultStore (
	input wire logic clock143Mhz,
	input wire logic reset_n,
	// one word per capture from the sequencer
	input wire memTestPkg::captureEvent_t captureEvent,
	input wire logic testDone,
	// display choice from the decoder
	input wire memTestPkg::slotSelect_t slotSelect,
	output logic compareError,
	output logic [memTestPkg::DISPLAY_WIDTH-1:0] displayValue
);
	import memTestPkg::*;

	// ------------------------------------------------------------------------
	// word record
	// ------------------------------------------------------------------------
	// written and read words, by slot
	logic [DATA_WIDTH-1:0] writtenWords [TEST_WORD_COUNT];
	logic [DATA_WIDTH-1:0] readWords [TEST_WORD_COUNT];

	logic readCapture;
	logic readMismatch;
	logic [DATA_WIDTH-1:0] selectedWord;

	assign readCapture = captureEvent.valid && (captureEvent.kind == accessRead);
	// read word against what went to the same slot
	assign readMismatch = captureEvent.data != writtenWords[captureEvent.slotIndex];

	// captured words land in the array for their kind
	always_ff @(posedge clock143Mhz) begin
		if (captureEvent.valid) begin
			if (captureEvent.kind == accessWrite) begin
				writtenWords[captureEvent.slotIndex] <= captureEvent.data;
			end else begin
				readWords[captureEvent.slotIndex] <= captureEvent.data;
			end
		end
	end

	// ------------------------------------------------------------------------
	// compare flag
	// ------------------------------------------------------------------------
	// sticky until reset
	always_ff @(posedge clock143Mhz) begin
		if (!reset_n) begin
			compareError <= 1'b0;
		end else if (readCapture && readMismatch) begin
			compareError <= 1'b1;
		end
	end

	// ------------------------------------------------------------------------
	// display
	// ------------------------------------------------------------------------
	// button picks written or read word
	assign selectedWord = slotSelect.showWritten ? writtenWords[slotSelect.slotIndex]
		: readWords[slotSelect.slotIndex];

	// idle value until done or with no switch set
	always_ff @(posedge clock143Mhz) begin
		if (!reset_n) begin
			displayValue <= IDLE_DISPLAY_VALUE;
		end else if (!testDone || !slotSelect.valid) begin
			displayValue <= IDLE_DISPLAY_VALUE;
		end else begin
			displayValue <= DISPLAY_WIDTH'(selectedWord);
		end
	end

	// ------------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------------
	// slot index comes from the sequencer counter
	captureInRange: assert property (@(posedge clock143Mhz) disable iff (!reset_n)
		captureEvent.valid |-> captureEvent.slotIndex < SLOT_INDEX_WIDTH'(TEST_WORD_COUNT))
		else $error("capture slot out of range");

endmodule

`default_nettype wire

//--- src/memTestTop.sv
`default_nettype none

module memTestTop (
	input wire logic clock143Mhz,
	input wire logic reset_n,
	// board inputs, asynchronous
	input wire logic [memTestPkg::TEST_WORD_COUNT-1:0] switches,
	input wire logic showWrittenButton,
	// sdram controller user port
	output memTestPkg::memRequest_t memRequest,
	output logic memRequestValid,
	input wire logic memAccepted,
	input wire logic memBusy,
	input wire logic memReadValid,
	input wire logic [memTestPkg::DATA_WIDTH-1:0] memReadData,
	// status and display
	output logic testDone,
	output logic compareError,
	output logic [memTestPkg::DISPLAY_WIDTH-1:0] displayValue
);
	import memTestPkg::*;

	// words seen on the user port, one cycle each
	captureEvent_t captureEvent;
	// chosen slot for the display
	slotSelect_t slotSelect;

	// ------------------------------------------------------------------------
	// memory access sequencing
	// ------------------------------------------------------------------------
	memTestSequencer sequencer_i (
		.clock143Mhz(clock143Mhz),
		.reset_n(reset_n),
		.memRequest(memRequest),
		.memRequestValid(memRequestValid),
		.memAccepted(memAccepted),
		.memBusy(memBusy),
		.memReadValid(memReadValid),
		.memReadData(memReadData),
		.captureEvent(captureEvent),
		.testDone(testDone)
	);

	// switches and button to a slot selection
	slotSelectDecoder decoder_i (
		.clock143Mhz(clock143Mhz),
		.reset_n(reset_n),
		.switches(switches),
		.showWrittenButton(showWrittenButton),
		.slotSelect(slotSelect)
	);

	// word record, compare and display
	resultStore results_i (
		.clock143Mhz(clock143Mhz),
		.reset_n(reset_n),
		.captureEvent(captureEvent),
		.testDone(testDone),
		.slotSelect(slotSelect),
		.compareError(compareError),
		.displayValue(displayValue)
	);

endmodule

`default_nettype wire

//--- verification/memTestChecker.sv
`default_nettype none

module memTestChecker (
	input wire logic clock143Mhz,
	input wire logic reset_n,
	// dut ports under watch
	input wire memTestPkg::memRequest_t memRequest,
	input wire logic memRequestValid,
	input wire logic memAccepted,
	input wire logic testDone,
	input wire logic compareError,
	input wire logic [memTestPkg::DISPLAY_WIDTH-1:0] displayValue,
	// expectations and strobes from the testbench
	input wire logic [8*24-1:0] testName,
	input wire logic [memTestPkg::DISPLAY_WIDTH-1:0] expectedDisplay,
	input wire logic expectedCompareError,
	input wire logic checkReset,
	input wire logic checkResult,
	input wire logic finishRun,
	output int errorCount
);
	timeunit 1ns;
	timeprecision 100ps;
	import memTestPkg::*;

	// accepted requests since reset, writes then reads
	int accessIndex = 0;
	int testErrors = 0;
	int testsRun = 0;
	int testsFailed = 0;
	// request seen last cycle and not yet taken
	logic requestPending = 1'b0;
	memRequest_t heldRequest;

	initial errorCount = 0;

	task automatic reportWrongValue(input string what, input longint expectedValue,
		input longint actualValue);
		$display("** Error %0s: %0s expected %0d, actual %0d", testName, what,
			expectedValue, actualValue);
		testErrors++;
		errorCount++;
	endtask

	task automatic reportFailure(input string message);
		$display("test %0s failed: %0s", testName, message);
		testErrors++;
		errorCount++;
	endtask

	// ------------------------------------------------------------------------
	// request order, address and data
	// ------------------------------------------------------------------------
	task automatic checkAcceptedRequest();
		int slot;
		accessKind_t expectedKind;
		slot = accessIndex % TEST_WORD_COUNT;
		expectedKind = (accessIndex < TEST_WORD_COUNT) ? accessWrite : accessRead;
		if (accessIndex >= 2 * TEST_WORD_COUNT) begin
			reportFailure("more requests than the write and read loops need");
		end else begin
			if (memRequest.kind != expectedKind) begin
				reportWrongValue("request kind", expectedKind, memRequest.kind);
			end
			if (memRequest.address != slot) begin
				reportWrongValue("request address", slot, memRequest.address);
			end
			// written word is base plus address
			if (expectedKind == accessWrite && memRequest.writeData != DATA_BASE_VALUE + slot) begin
				reportWrongValue("write data", DATA_BASE_VALUE + slot, memRequest.writeData);
			end
		end
	endtask

	always @(posedge clock143Mhz) begin
		if (!reset_n) begin
			accessIndex = 0;
			testErrors = 0;
			requestPending = 1'b0;
		end else begin
			if (checkReset) begin
				if (memRequestValid || testDone || compareError) begin
					reportFailure("a status output was high right after reset");
				end
				if (displayValue != IDLE_DISPLAY_VALUE) begin
					reportWrongValue("display after reset", IDLE_DISPLAY_VALUE, displayValue);
				end
			end
			// a waiting request keeps valid and payload
			if (requestPending && (!memRequestValid || memRequest != heldRequest)) begin
				reportFailure("request changed or dropped before it was accepted");
			end
			if (memRequestValid && memAccepted) begin
				checkAcceptedRequest();
				accessIndex++;
			end
			requestPending = memRequestValid && !memAccepted;
			heldRequest = memRequest;
			// ----------------------------------------------------------------
			// end of one test
			// ----------------------------------------------------------------
			if (checkResult) begin
				testsRun++;
				if (accessIndex != 2 * TEST_WORD_COUNT) begin
					reportFailure($sformatf("%0d requests accepted, not 20", accessIndex));
				end
				if (!testDone) begin
					reportFailure("testDone was low when the result was checked");
				end
				if (compareError !== expectedCompareError) begin
					reportWrongValue("compareError", expectedCompareError, compareError);
				end
				if (displayValue !== expectedDisplay) begin
					reportWrongValue("displayValue", expectedDisplay, displayValue);
				end
				if (testErrors == 0) begin
					$display("PASS %0s", testName);
				end else begin
					testsFailed++;
					$display("FAIL %0s with %0d errors", testName, testErrors);
				end
			end
		end
		if (finishRun) begin
			$display("tests run %0d, passed %0d, failed %0d, errors %0d", testsRun,
				testsRun - testsFailed, testsFailed, errorCount);
		end
	end

endmodule

`default_nettype wire

//--- verification/memTestTb.sv
`default_nettype none

module memTestTb;
	timeunit 1ns;
	timeprecision 100ps;
	import memTestPkg::*;

	logic clock143Mhz;
	logic reset_n = 1'b0;
	logic [TEST_WORD_COUNT-1:0] switches = '0;
	logic showWrittenButton = 1'b0;
	memRequest_t memRequest;
	logic memRequestValid;
	// controller side, driven by the memory model
	logic memAccepted = 1'b0;
	logic memBusy = 1'b1;
	logic memReadValid = 1'b0;
	logic [DATA_WIDTH-1:0] memReadData = '0;
	logic testDone;
	logic compareError;
	logic [DISPLAY_WIDTH-1:0] displayValue;

	// current test for the checker
	logic [8*24-1:0] testName = '0;
	logic [DISPLAY_WIDTH-1:0] expectedDisplay = '0;
	logic expectedCompareError = 1'b0;
	logic checkReset = 1'b0;
	logic checkResult = 1'b0;
	logic finishRun = 1'b0;
	int errorCount;

	// read fault, -1 for none
	int faultSlot = -1;
	logic [DATA_WIDTH-1:0] faultMask = '0;

	// pattern table
	logic [8*24-1:0] patternNames [$];
	int patternFaultSlots [$];
	logic [DATA_WIDTH-1:0] patternMasks [$];
	logic [TEST_WORD_COUNT-1:0] patternSwitches [$];
	logic patternButtons [$];
	logic [DISPLAY_WIDTH-1:0] patternDisplays [$];
	logic patternErrors [$];

	int cycleCount = 0;
	int timeoutLimit = 0;
	int seedValue;

	// memory model
	typedef enum {modelInit, modelIdle, modelAccept, modelBusy} modelState_t;
	modelState_t modelState = modelInit;
	int delayCount = 0;
	logic resetSeen = 1'b0;
	logic [DATA_WIDTH-1:0] memWords [16];
	logic [SLOT_INDEX_WIDTH-1:0] pendingSlot = '0;
	accessKind_t pendingKind = accessWrite;

	memTestTop dut_i (.*);

	memTestChecker checker_i (.*);

	initial begin
		clock143Mhz = 1'b0;
		forever #4 clock143Mhz = ~clock143Mhz;
	end

	// run-wide limit
	always @(posedge clock143Mhz) begin
		cycleCount++;
		if (cycleCount > timeoutLimit) begin
			$display("timeout: the tests did not finish within %0d cycles", timeoutLimit);
			$display("Done: errors found");
			$finish;
		end
	end

	// ------------------------------------------------------------------------
	// controller model, accept and busy delays of 1 to 6 cycles
	// ------------------------------------------------------------------------
	always @(posedge clock143Mhz) begin
		resetSeen <= reset_n;
	end

	always @(negedge clock143Mhz) begin
		if (!resetSeen) begin
			// init busy, as after power-up
			modelState = modelInit;
			delayCount = $urandom_range(6, 1);
			memAccepted = 1'b0;
			memBusy = 1'b1;
			memReadValid = 1'b0;
		end else begin
			case (modelState)
				modelInit: begin
					delayCount--;
					if (delayCount == 0) begin
						memBusy = 1'b0;
						modelState = modelIdle;
					end
				end
				modelIdle: begin
					if (memRequestValid) begin
						delayCount = $urandom_range(6, 1);
						modelState = modelAccept;
					end
				end
				modelAccept: begin
					delayCount--;
					if (delayCount == 0) begin
						memAccepted = 1'b1;
						memBusy = 1'b1;
						pendingSlot = memRequest.address[SLOT_INDEX_WIDTH-1:0];
						pendingKind = memRequest.kind;
						if (memRequest.kind == accessWrite) begin
							memWords[pendingSlot] = memRequest.writeData;
						end
						delayCount = $urandom_range(6, 1);
						modelState = modelBusy;
					end
				end
				modelBusy: begin
					memAccepted = 1'b0;
					// read data in the last busy cycle
					memReadValid = (delayCount == 1) && (pendingKind == accessRead);
					memReadData = memWords[pendingSlot]
						^ ((int'(pendingSlot) == faultSlot) ? faultMask : '0);
					if (delayCount == 0) begin
						memBusy = 1'b0;
						modelState = modelIdle;
					end else begin
						delayCount--;
					end
				end
			endcase
		end
	end

	// ------------------------------------------------------------------------
	// patterns and stimulus
	// ------------------------------------------------------------------------
	task automatic readPatterns();
		int fd;
		string line;
		logic [8*24-1:0] nameText;
		logic [8*24-1:0] faultText;
		logic [DATA_WIDTH-1:0] maskValue;
		logic [TEST_WORD_COUNT-1:0] switchValue;
		logic buttonValue;
		int displayNumber;
		logic errorBit;
		fd = $fopen("verification/memTestPatterns.txt", "r");
		if (fd != 0) begin
			while ($fgets(line, fd) != 0) begin
				if (line.len() > 1 && line[0] != "#") begin
					if ($sscanf(line, "%s %s %h %b %b %d %b", nameText, faultText, maskValue,
						switchValue, buttonValue, displayNumber, errorBit) == 7) begin
						patternNames.push_back(nameText);
						// slots are one digit
						patternFaultSlots.push_back((faultText == "none") ? -1
							: int'(faultText[7:0]) - 48);
						patternMasks.push_back(maskValue);
						patternSwitches.push_back(switchValue);
						patternButtons.push_back(buttonValue);
						patternDisplays.push_back(DISPLAY_WIDTH'(displayNumber));
						patternErrors.push_back(errorBit);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic runTest(input int index);
		@(negedge clock143Mhz);
		reset_n = 1'b0;
		switches = '0;
		showWrittenButton = 1'b0;
		testName = patternNames[index];
		faultSlot = patternFaultSlots[index];
		faultMask = patternMasks[index];
		expectedDisplay = patternDisplays[index];
		expectedCompareError = patternErrors[index];
		repeat (16) @(negedge clock143Mhz);
		reset_n = 1'b1;
		checkReset = 1'b1;
		@(negedge clock143Mhz);
		checkReset = 1'b0;
		while (!testDone) begin
			@(negedge clock143Mhz);
		end
		switches = patternSwitches[index];
		showWrittenButton = patternButtons[index];
		// synchronizer, decoder and display registers
		repeat (8) @(negedge clock143Mhz);
		checkResult = 1'b1;
		@(negedge clock143Mhz);
		checkResult = 1'b0;
	endtask

	initial begin
		seedValue = $urandom(32'h7775);
		readPatterns();
		// reset, two settles, pause, 20 accesses of 14 cycles, margin, doubled
		timeoutLimit = 2 * patternNames.size() * (16 + 2 * STARTUP_SETTLE_CYCLES
			+ READBACK_PAUSE_CYCLES + 2 * TEST_WORD_COUNT * 14 + 20);
		if (patternNames.size() == 0) begin
			$display("no tests could be read from verification/memTestPatterns.txt");
			$display("Done: errors found");
			$finish;
		end else begin
			foreach (patternNames[i]) begin
				runTest(i);
			end
			@(negedge clock143Mhz);
			finishRun = 1'b1;
			@(negedge clock143Mhz);
			finishRun = 1'b0;
			if (errorCount == 0) begin
				$display("Done: no errors");
			end else begin
				$display("Done: errors found");
			end
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- verilog.f
src/memTestPkg.sv
src/memTestSequencer.sv
src/slotSelectDecoder.sv
src/resultStore.sv
src/memTestTop.sv
verification/memTestChecker.sv
verification/memTestTb.sv

//--- verification/memTestPatterns.txt
# name faultSlot(none or 0-9) xorMaskHex switches(bit9..bit0) button expectedDisplay
# last column is the expected compareError, button 1 shows the written word
noFaultSlot0 none 0000 0000000001 0 100 0
noFaultSlot9 none 0000 1000000000 0 109 0
noFaultWritten5 none 0000 0000100000 1 105 0
noSwitches none 0000 0000000000 0 191919 0
lowestWins none 0000 0110010000 0 104 0
allSwitches none 0000 1111111111 0 100 0
faultRead3 3 00ff 0000001000 0 152 1
faultWritten3 3 00ff 0000001000 1 103 1
faultOtherSlot 7 8000 0000000100 0 102 1
faultRead0 0 ffff 0000000001 0 65435 1
faultHigh9 9 0001 1000000000 0 108 1
faultNoSwitch 6 0f0f 0000000000 1 191919 1
multiFaultLowest 5 0010 1111100000 0 121 1
faultRead8 8 0100 0100000000 0 364 1
faultMaskAll 1 ffff 0000000010 0 65434 1
